//--- source/rx_frame_pkg.sv
`default_nettype none

package rx_frame_pkg;

	// Field widths
	localparam int WORD_W = 32;
	localparam int ADDR_W = 16;
	localparam int LEN_W = 16;
	localparam int CSUM_W = 16;
	localparam int KEEP_W = WORD_W / 8;
	localparam int BURST_LEN_W = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LEN_W-1:0] len_t;
	typedef logic [CSUM_W-1:0] csum_t;
	typedef logic [KEEP_W-1:0] keep_t;
	typedef logic [BURST_LEN_W-1:0] burst_len_t;

	// Flag bits of report word 2
	localparam int RPT_ERR_BIT = 0;
	localparam int RPT_TRUNC_BIT = 1;

	typedef enum logic [2:0] {
		WDMA_IDLE,
		WDMA_FILL,
		WDMA_ADDR,
		WDMA_DATA,
		WDMA_RESP,
		WDMA_DONE
	} wdma_state_e;

	typedef enum logic [2:0] {
		RPT_IDLE,
		RPT_WAIT,
		RPT_WORD0,
		RPT_WORD1,
		RPT_WORD2
	} rpt_state_e;

endpackage

`default_nettype wire

//--- source/rx_buf_queue.sv
`default_nettype none

module rx_buf_queue #(
	parameter int CMD_DEPTH = 4
) (
	input wire aclk,
	input wire aresetn,
	input wire rx_frame_pkg::word_t cmd_tdata,
	input wire cmd_tvalid,
	output logic cmd_tready,
	output rx_frame_pkg::len_t buf_len,
	output rx_frame_pkg::addr_t buf_addr,
	output logic buf_valid,
	input wire buf_pop
);
	import rx_frame_pkg::*;

	localparam int PTR_W = $clog2(CMD_DEPTH);

	word_t mem [CMD_DEPTH];
	word_t head;
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic full;
	logic empty;
	logic push;

	// Extra pointer bit tells full from empty
	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign push = cmd_tvalid && !full;

	assign cmd_tready = !full;
	assign buf_valid = !empty;

	// Head word falls through to the DMA
	assign head = mem[rd_ptr[PTR_W-1:0]];
	assign buf_len = head[31:16];
	assign buf_addr = head[15:0];

	always_ff @(posedge aclk) begin
		if (push)
			mem[wr_ptr[PTR_W-1:0]] <= cmd_tdata;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (buf_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// DMA only pops a posted buffer
	assert property (@(posedge aclk) disable iff (!aresetn) buf_pop |-> buf_valid)
		else $error("buffer queue popped while empty");

endmodule

`default_nettype wire

//--- source/rx_frame_wdma.sv
`default_nettype none

module rx_frame_wdma #(
	parameter int BURST_BEATS = 16
) (
	input wire aclk,
	input wire aresetn,
	input wire rx_frame_pkg::len_t buf_len,
	input wire rx_frame_pkg::addr_t buf_addr,
	input wire buf_valid,
	output logic buf_pop,
	input wire rx_frame_pkg::word_t mac_tdata,
	input wire rx_frame_pkg::keep_t mac_tkeep,
	input wire mac_tvalid,
	input wire mac_tlast,
	output logic mac_tready,
	output logic beat_take,
	output rx_frame_pkg::addr_t awaddr,
	output rx_frame_pkg::burst_len_t awlen,
	output logic awvalid,
	input wire awready,
	output rx_frame_pkg::word_t wdata,
	output rx_frame_pkg::keep_t wstrb,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire [1:0] bresp,
	input wire bvalid,
	output logic frame_done,
	output rx_frame_pkg::len_t frame_len,
	output rx_frame_pkg::addr_t frame_addr,
	output logic wr_err,
	output logic trunc,
	input wire rpt_ack
);
	import rx_frame_pkg::*;

	localparam int CNT_W = $clog2(BURST_BEATS + 1);
	localparam int IDX_W = $clog2(BURST_BEATS);

	wdma_state_e state;
	word_t burst_data [BURST_BEATS];
	keep_t burst_keep [BURST_BEATS];
	logic [CNT_W-1:0] fill_cnt;
	logic [CNT_W-1:0] fill_next;
	logic [IDX_W-1:0] beat_idx;
	len_t buf_len_q;
	addr_t wr_addr;
	logic last_seen;
	logic [2:0] beat_bytes;
	logic beat_fit;
	logic mac_acc;

	// A beat is written only if all its bytes fit, and nothing after the first drop
	assign beat_bytes = 3'($countones(mac_tkeep));
	assign beat_fit = !trunc &&
		(({1'b0, frame_len} + 17'(beat_bytes)) <= {1'b0, buf_len_q});

	assign buf_pop = (state == WDMA_IDLE) && buf_valid;
	assign mac_tready = (state == WDMA_FILL) && (fill_cnt < CNT_W'(BURST_BEATS));
	assign mac_acc = mac_tvalid && mac_tready;
	assign beat_take = mac_acc && beat_fit;
	assign fill_next = fill_cnt + CNT_W'(beat_take);

	assign awvalid = state == WDMA_ADDR;
	assign awaddr = wr_addr;
	assign awlen = burst_len_t'(fill_cnt - 1'b1);

	assign wvalid = state == WDMA_DATA;
	assign wdata = burst_data[beat_idx];
	assign wstrb = burst_keep[beat_idx];
	assign wlast = (CNT_W'(beat_idx) + 1'b1) == fill_cnt;

	always_ff @(posedge aclk) begin
		if (beat_take) begin
			burst_data[IDX_W'(fill_cnt)] <= mac_tdata;
			burst_keep[IDX_W'(fill_cnt)] <= mac_tkeep;
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= WDMA_IDLE;
			fill_cnt <= '0;
			beat_idx <= '0;
			buf_len_q <= '0;
			wr_addr <= '0;
			frame_addr <= '0;
			frame_len <= '0;
			last_seen <= 1'b0;
			wr_err <= 1'b0;
			trunc <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				WDMA_IDLE: begin
					if (buf_valid) begin
						buf_len_q <= buf_len;
						wr_addr <= buf_addr;
						frame_addr <= buf_addr;
						frame_len <= '0;
						fill_cnt <= '0;
						last_seen <= 1'b0;
						wr_err <= 1'b0;
						trunc <= 1'b0;
						state <= WDMA_FILL;
					end
				end
				WDMA_FILL: begin
					if (mac_acc) begin
						fill_cnt <= fill_next;
						if (beat_fit)
							frame_len <= frame_len + len_t'(beat_bytes);
						else
							trunc <= 1'b1;
						if (mac_tlast) begin
							last_seen <= 1'b1;
							// Nothing left to write, finish without a burst
							if (fill_next == '0) begin
								frame_done <= 1'b1;
								state <= WDMA_DONE;
							end else begin
								state <= WDMA_ADDR;
							end
						end else if (fill_next == CNT_W'(BURST_BEATS)) begin
							state <= WDMA_ADDR;
						end
					end
				end
				WDMA_ADDR: begin
					if (awready) begin
						beat_idx <= '0;
						state <= WDMA_DATA;
					end
				end
				WDMA_DATA: begin
					if (wready) begin
						beat_idx <= beat_idx + 1'b1;
						wr_addr <= wr_addr + addr_t'(KEEP_W);
						if (wlast)
							state <= WDMA_RESP;
					end
				end
				WDMA_RESP: begin
					if (bvalid) begin
						// Anything but OKAY
						if (bresp != 2'b00)
							wr_err <= 1'b1;
						fill_cnt <= '0;
						if (last_seen) begin
							frame_done <= 1'b1;
							state <= WDMA_DONE;
						end else begin
							state <= WDMA_FILL;
						end
					end
				end
				WDMA_DONE: begin
					if (rpt_ack)
						state <= WDMA_IDLE;
				end
				default: state <= WDMA_IDLE;
			endcase
		end
	end

	assert property (@(posedge aclk) disable iff (!aresetn)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
		else $error("write address changed before awready");

	// Data phase ends after the beat numbered awlen and no other
	assert property (@(posedge aclk) disable iff (!aresetn)
		wvalid && wready |=> wvalid == (burst_len_t'($past(beat_idx)) != $past(awlen)))
		else $error("burst did not end on beat awlen");

endmodule

`default_nettype wire

//--- source/rx_checksum.sv
`default_nettype none

module rx_checksum (
	input wire aclk,
	input wire aresetn,
	input wire rx_frame_pkg::word_t mac_tdata,
	input wire rx_frame_pkg::keep_t mac_tkeep,
	input wire beat_take,
	input wire [7:0] pcss,
	input wire rpt_ack,
	output rx_frame_pkg::csum_t csum
);
	import rx_frame_pkg::*;

	// Frame byte offset of byte 0 of the current beat
	len_t beat_off;
	word_t masked;

	always_comb begin
		masked = '0;
		for (int i = 0; i < KEEP_W; i++) begin
			if (mac_tkeep[i] && ((beat_off + len_t'(i)) >= len_t'(pcss)))
				masked[8*i +: 8] = mac_tdata[8*i +: 8];
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			beat_off <= '0;
			csum <= '0;
		end else if (rpt_ack) begin
			beat_off <= '0;
			csum <= '0;
		end else if (beat_take) begin
			beat_off <= beat_off + len_t'(KEEP_W);
			// Plain wrapping sum of both halves
			csum <= csum + masked[31:16] + masked[15:0];
		end
	end

endmodule

`default_nettype wire

//--- source/rx_report.sv
`default_nettype none

module rx_report (
	input wire aclk,
	input wire aresetn,
	input wire frame_done,
	input wire rx_frame_pkg::len_t frame_len,
	input wire rx_frame_pkg::addr_t frame_addr,
	input wire wr_err,
	input wire trunc,
	input wire rx_frame_pkg::csum_t csum,
	output rx_frame_pkg::word_t stat_tdata,
	output logic stat_tvalid,
	output logic stat_tlast,
	input wire stat_tready,
	output logic rpt_ack
);
	import rx_frame_pkg::*;

	rpt_state_e state;
	word_t flags;

	always_comb begin
		flags = '0;
		flags[RPT_ERR_BIT] = wr_err;
		flags[RPT_TRUNC_BIT] = trunc;
	end

	assign stat_tvalid = state inside {RPT_WORD0, RPT_WORD1, RPT_WORD2};
	assign stat_tlast = state == RPT_WORD2;
	assign rpt_ack = stat_tlast && stat_tready;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= RPT_IDLE;
		end else begin
			case (state)
				// One quiet cycle while the DMA drops back to idle
				RPT_IDLE: state <= RPT_WAIT;
				RPT_WAIT: if (frame_done) state <= RPT_WORD0;
				RPT_WORD0: if (stat_tready) state <= RPT_WORD1;
				RPT_WORD1: if (stat_tready) state <= RPT_WORD2;
				RPT_WORD2: if (stat_tready) state <= RPT_IDLE;
				default: state <= RPT_IDLE;
			endcase
		end
	end

	// Next report word is loaded as the current one is taken
	always_ff @(posedge aclk) begin
		case (state)
			RPT_WAIT: if (frame_done) stat_tdata <= {frame_len, frame_addr};
			RPT_WORD0: if (stat_tready) stat_tdata <= word_t'(csum);
			RPT_WORD1: if (stat_tready) stat_tdata <= flags;
			default: ;
		endcase
	end

	assert property (@(posedge aclk) disable iff (!aresetn)
		stat_tvalid && !stat_tready |=> stat_tvalid && $stable(stat_tdata))
		else $error("report word changed while stalled");

	// DMA must not finish a frame while a report is still out
	assert property (@(posedge aclk) disable iff (!aresetn)
		frame_done |-> state == RPT_WAIT)
		else $error("frame_done while report busy");

endmodule

`default_nettype wire

//--- source/rx_frame.sv
`default_nettype none

module rx_frame #(
	parameter int CMD_DEPTH = 4,
	parameter int BURST_BEATS = 16
) (
	input wire aclk,
	input wire aresetn,
	input wire [7:0] pcss,
	input wire rx_frame_pkg::word_t cmd_tdata,
	input wire cmd_tvalid,
	output wire cmd_tready,
	output wire rx_frame_pkg::word_t stat_tdata,
	output wire stat_tvalid,
	output wire stat_tlast,
	input wire stat_tready,
	input wire rx_frame_pkg::word_t mac_tdata,
	input wire rx_frame_pkg::keep_t mac_tkeep,
	input wire mac_tvalid,
	input wire mac_tlast,
	output wire mac_tready,
	output wire rx_frame_pkg::addr_t awaddr,
	output wire rx_frame_pkg::burst_len_t awlen,
	output wire awvalid,
	input wire awready,
	output wire rx_frame_pkg::word_t wdata,
	output wire rx_frame_pkg::keep_t wstrb,
	output wire wlast,
	output wire wvalid,
	input wire wready,
	input wire [1:0] bresp,
	input wire bvalid
);
	import rx_frame_pkg::*;

	wire len_t buf_len;
	wire addr_t buf_addr;
	wire buf_valid;
	wire buf_pop;
	wire beat_take;
	wire frame_done;
	wire len_t frame_len;
	wire addr_t frame_addr;
	wire wr_err;
	wire trunc;
	wire csum_t csum;
	wire rpt_ack;

	rx_buf_queue #(.CMD_DEPTH(CMD_DEPTH)) i_rx_buf_queue (
		.aclk(aclk), .aresetn(aresetn),
		.cmd_tdata(cmd_tdata), .cmd_tvalid(cmd_tvalid), .cmd_tready(cmd_tready),
		.buf_len(buf_len), .buf_addr(buf_addr), .buf_valid(buf_valid), .buf_pop(buf_pop)
	);

	rx_frame_wdma #(.BURST_BEATS(BURST_BEATS)) i_rx_frame_wdma (
		.aclk(aclk), .aresetn(aresetn),
		.buf_len(buf_len), .buf_addr(buf_addr), .buf_valid(buf_valid), .buf_pop(buf_pop),
		.mac_tdata(mac_tdata), .mac_tkeep(mac_tkeep), .mac_tvalid(mac_tvalid),
		.mac_tlast(mac_tlast), .mac_tready(mac_tready), .beat_take(beat_take),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid),
		.frame_done(frame_done), .frame_len(frame_len), .frame_addr(frame_addr),
		.wr_err(wr_err), .trunc(trunc), .rpt_ack(rpt_ack)
	);

	rx_checksum i_rx_checksum (
		.aclk(aclk), .aresetn(aresetn),
		.mac_tdata(mac_tdata), .mac_tkeep(mac_tkeep), .beat_take(beat_take),
		.pcss(pcss), .rpt_ack(rpt_ack), .csum(csum)
	);

	rx_report i_rx_report (
		.aclk(aclk), .aresetn(aresetn),
		.frame_done(frame_done), .frame_len(frame_len), .frame_addr(frame_addr),
		.wr_err(wr_err), .trunc(trunc), .csum(csum),
		.stat_tdata(stat_tdata), .stat_tvalid(stat_tvalid), .stat_tlast(stat_tlast),
		.stat_tready(stat_tready), .rpt_ack(rpt_ack)
	);

endmodule

`default_nettype wire

//--- test/tb_dram_model.sv
`default_nettype none

module tb_dram_model (
	input wire aclk,
	input wire aresetn,
	input wire rx_frame_pkg::addr_t awaddr,
	input wire rx_frame_pkg::burst_len_t awlen,
	input wire awvalid,
	output logic awready,
	input wire rx_frame_pkg::word_t wdata,
	input wire rx_frame_pkg::keep_t wstrb,
	input wire wlast,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire stall_en,
	input wire force_err
);
	timeunit 1ns;
	timeprecision 100ps;

	import rx_frame_pkg::*;

	logic [7:0] mem [65536];
	logic [31:0] lfsr = 32'hd784_5796;
	addr_t cur_addr;
	logic have_addr;
	logic b_pending;
	burst_len_t len_q;
	burst_len_t beat_cnt;
	int burst_errs = 0;

	// Taps 32, 22, 2, 1
	function automatic logic step_lfsr();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// Background pattern over the whole address
	initial begin
		for (int a = 0; a < 65536; a++)
			mem[a] = 8'(a) ^ {1'(a >> 15), 7'(a >> 8)} ^ 8'h5a;
	end

	always @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			cur_addr <= '0;
			have_addr <= 1'b0;
			b_pending <= 1'b0;
			len_q <= '0;
			beat_cnt <= '0;
		end else begin
			if (awvalid && awready) begin
				cur_addr <= awaddr;
				have_addr <= 1'b1;
				len_q <= awlen;
				beat_cnt <= '0;
			end
			if (wvalid && wready) begin
				for (int k = 0; k < KEEP_W; k++) begin
					if (wstrb[k])
						mem[cur_addr + addr_t'(k)] <= wdata[8*k +: 8];
				end
				cur_addr <= cur_addr + addr_t'(KEEP_W);
				// Burst closes on beat awlen
				assert (wlast == (beat_cnt == len_q))
				else begin
					$display("Fail at %0t: wlast expected %b actual %b", $time,
						beat_cnt == len_q, wlast);
					burst_errs++;
				end
				beat_cnt <= beat_cnt + 1'b1;
				if (wlast) begin
					have_addr <= 1'b0;
					b_pending <= 1'b1;
				end
			end
			// bready is always high in the DUT
			if (bvalid)
				b_pending <= 1'b0;
		end
	end

	always @(negedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= 2'b00;
		end else begin
			awready <= stall_en ? step_lfsr() : 1'b1;
			wready <= have_addr && (stall_en ? step_lfsr() : 1'b1);
			bvalid <= b_pending;
			// SLVERR when asked for
			bresp <= force_err ? 2'b10 : 2'b00;
		end
	end

endmodule

`default_nettype wire

//--- test/tb_rx_frame.sv
`default_nettype none

module tb_rx_frame;
	timeunit 1ns;
	timeprecision 100ps;

	import rx_frame_pkg::*;

	localparam int N = 8;
	localparam int MAXB = 128;
	localparam int WAIT_LIMIT = 4000;
	localparam int RUN_LIMIT = 60000;

	// Buffer address, buffer length, frame length, pcss, stall, error response
	addr_t tbl_addr [N] = '{16'h0100, 16'h0200, 16'h0300, 16'h0400,
		16'h0500, 16'h0600, 16'h0700, 16'h0800};
	int tbl_blen [N] = '{64, 64, 128, 20, 64, 96, 48, 30};
	int tbl_flen [N] = '{40, 37, 100, 33, 50, 90, 45, 31};
	int tbl_pcss [N] = '{0, 3, 9, 0, 5, 2, 7, 1};
	bit tbl_stall [N] = '{0, 0, 0, 0, 0, 1, 1, 1};
	bit tbl_err [N] = '{0, 0, 0, 0, 1, 0, 1, 0};

	logic aclk = 1'b0;
	logic aresetn;
	logic [7:0] pcss;
	word_t cmd_tdata;
	logic cmd_tvalid;
	wire cmd_tready;
	wire word_t stat_tdata;
	wire stat_tvalid;
	wire stat_tlast;
	logic stat_tready;
	word_t mac_tdata;
	keep_t mac_tkeep;
	logic mac_tvalid;
	logic mac_tlast;
	wire mac_tready;
	wire addr_t awaddr;
	wire burst_len_t awlen;
	wire awvalid;
	wire awready;
	wire word_t wdata;
	wire keep_t wstrb;
	wire wlast;
	wire wvalid;
	wire wready;
	wire [1:0] bresp;
	wire bvalid;
	logic stall_en;
	logic force_err;

	logic [31:0] lfsr = 32'hd784_5796;
	logic [7:0] fdata [N][MAXB];
	len_t exp_len [N];
	csum_t exp_csum [N];
	word_t exp_flags [N];
	int value_errs = 0;
	int timeout_errs = 0;
	int reports_done = 0;
	bit stuck = 1'b0;
	bit all_done = 1'b0;

	always #50 aclk = ~aclk;

	rx_frame #(.CMD_DEPTH(4), .BURST_BEATS(16)) i_rx_frame (
		.aclk(aclk), .aresetn(aresetn), .pcss(pcss),
		.cmd_tdata(cmd_tdata), .cmd_tvalid(cmd_tvalid), .cmd_tready(cmd_tready),
		.stat_tdata(stat_tdata), .stat_tvalid(stat_tvalid), .stat_tlast(stat_tlast),
		.stat_tready(stat_tready),
		.mac_tdata(mac_tdata), .mac_tkeep(mac_tkeep), .mac_tvalid(mac_tvalid),
		.mac_tlast(mac_tlast), .mac_tready(mac_tready),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid)
	);

	tb_dram_model i_dram (
		.aclk(aclk), .aresetn(aresetn),
		.awaddr(awaddr), .awlen(awlen), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .stall_en(stall_en), .force_err(force_err)
	);

	function automatic logic step_lfsr();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int j = 0; j < 8; j++)
			b = {b[6:0], step_lfsr()};
		return b;
	endfunction

	function automatic logic [7:0] fill_byte(input addr_t a);
		return a[7:0] ^ {a[15], a[14:8]} ^ 8'h5a;
	endfunction

	task automatic check_value(input string name, input word_t exp, input word_t act);
		assert (exp == act)
		else begin
			$display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		timeout_errs++;
		stuck = 1'b1;
	endtask

	// Frame bytes and the report each frame should produce
	task automatic build_expected();
		int wr;
		int nb;
		bit tr;
		csum_t sum;
		for (int i = 0; i < N; i++) begin
			for (int k = 0; k < MAXB; k++)
				fdata[i][k] = random_byte();
			wr = 0;
			tr = 1'b0;
			sum = '0;
			for (int b = 0; b < (tbl_flen[i] + 3) / 4; b++) begin
				nb = (tbl_flen[i] - 4 * b < 4) ? tbl_flen[i] - 4 * b : 4;
				if (!tr && wr + nb <= tbl_blen[i]) begin
					for (int k = 0; k < nb; k++) begin
						if (4 * b + k >= tbl_pcss[i])
							sum = sum + (csum_t'(fdata[i][4*b+k]) << (8 * (k % 2)));
					end
					wr = wr + nb;
				end else begin
					tr = 1'b1;
				end
			end
			exp_len[i] = len_t'(wr);
			exp_csum[i] = sum;
			exp_flags[i] = '0;
			exp_flags[i][RPT_TRUNC_BIT] = tr;
			exp_flags[i][RPT_ERR_BIT] = tbl_err[i];
		end
	endtask

	task automatic post_cmds();
		int n;
		for (int i = 0; i < N; i++) begin
			@(negedge aclk);
			cmd_tdata = {len_t'(tbl_blen[i]), tbl_addr[i]};
			cmd_tvalid = 1'b1;
			n = 0;
			while (!cmd_tready && !stuck) begin
				@(negedge aclk);
				n++;
				if (n > WAIT_LIMIT)
					report_timeout($sformatf("command %0d never accepted", i));
			end
		end
		@(negedge aclk);
		cmd_tvalid = 1'b0;
	endtask

	task automatic send_frames();
		int n;
		int nb;
		int nbeats;
		for (int i = 0; i < N; i++) begin
			// Next frame only after the previous report is out
			n = 0;
			while (reports_done < i && !stuck) begin
				@(negedge aclk);
				n++;
				if (n > WAIT_LIMIT)
					report_timeout($sformatf("report %0d never finished", i - 1));
			end
			pcss = 8'(tbl_pcss[i]);
			stall_en = tbl_stall[i];
			force_err = tbl_err[i];
			nbeats = (tbl_flen[i] + 3) / 4;
			for (int b = 0; b < nbeats; b++) begin
				@(negedge aclk);
				nb = (tbl_flen[i] - 4 * b < 4) ? tbl_flen[i] - 4 * b : 4;
				for (int k = 0; k < 4; k++)
					mac_tdata[8*k +: 8] = (k < nb) ? fdata[i][4*b+k] : 8'h00;
				mac_tkeep = keep_t'((1 << nb) - 1);
				mac_tlast = b == nbeats - 1;
				mac_tvalid = 1'b1;
				n = 0;
				while (!mac_tready && !stuck) begin
					@(negedge aclk);
					n++;
					if (n > WAIT_LIMIT)
						report_timeout($sformatf("frame %0d beat %0d never taken", i, b));
				end
			end
			@(negedge aclk);
			mac_tvalid = 1'b0;
			mac_tlast = 1'b0;
		end
	endtask

	task automatic get_word(input bit stall, output word_t data, output logic last);
		int n;
		bit got;
		n = 0;
		got = 1'b0;
		data = '0;
		last = 1'b0;
		while (!got && !stuck) begin
			@(negedge aclk);
			stat_tready = stall ? step_lfsr() : 1'b1;
			if (stat_tvalid && stat_tready) begin
				data = stat_tdata;
				last = stat_tlast;
				got = 1'b1;
			end else begin
				n++;
				if (n > WAIT_LIMIT)
					report_timeout("no report word from the DUT");
			end
		end
	endtask

	task automatic check_memory(input int i);
		addr_t a;
		logic [7:0] e;
		// A few bytes on either side of the buffer too
		for (int k = -4; k < tbl_blen[i] + 8; k++) begin
			a = addr_t'(int'(tbl_addr[i]) + k);
			e = (k >= 0 && k < int'(exp_len[i])) ? fdata[i][k] : fill_byte(a);
			check_value($sformatf("mem[%h]", a), word_t'(e), word_t'(i_dram.mem[a]));
		end
	endtask

	task automatic collect_reports();
		word_t data;
		logic last;
		for (int i = 0; i < N; i++) begin
			get_word(tbl_stall[i], data, last);
			check_value("stat_tdata word0", {exp_len[i], tbl_addr[i]}, data);
			check_value("stat_tlast word0", '0, word_t'(last));
			get_word(tbl_stall[i], data, last);
			check_value("stat_tdata word1", word_t'(exp_csum[i]), data);
			check_value("stat_tlast word1", '0, word_t'(last));
			get_word(tbl_stall[i], data, last);
			check_value("stat_tdata word2", exp_flags[i], data);
			check_value("stat_tlast word2", 32'd1, word_t'(last));
			check_memory(i);
			reports_done++;
		end
		all_done = 1'b1;
	endtask

	initial begin
		int n;
		aresetn = 1'b0;
		pcss = '0;
		cmd_tdata = '0;
		cmd_tvalid = 1'b0;
		stat_tready = 1'b0;
		mac_tdata = '0;
		mac_tkeep = '0;
		mac_tvalid = 1'b0;
		mac_tlast = 1'b0;
		stall_en = 1'b0;
		force_err = 1'b0;
		build_expected();
		repeat (5) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
		fork
			post_cmds();
			send_frames();
			collect_reports();
		join_none
		n = 0;
		while (!all_done && !stuck && n < RUN_LIMIT) begin
			@(negedge aclk);
			n++;
		end
		if (n >= RUN_LIMIT) begin
			$display("Run did not finish within %0d cycles", RUN_LIMIT);
			timeout_errs++;
		end
		$display("Errors: %0d value, %0d burst, %0d timeout", value_errs, i_dram.burst_errs,
			timeout_errs);
		if (value_errs == 0 && i_dram.burst_errs == 0 && timeout_errs == 0 && all_done)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- rx_frame.f
source/rx_frame_pkg.sv
source/rx_buf_queue.sv
source/rx_frame_wdma.sv
source/rx_checksum.sv
source/rx_report.sv
source/rx_frame.sv
test/tb_dram_model.sv
test/tb_rx_frame.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the receive-path simulation with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rx_frame -f rx_frame.f &&
./obj_dir/Vtb_rx_frame | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "Simulation passed" ||
{
	echo "Simulation failed"
	exit 1
}
